//--- include/accel_rd_dma_defs.svh
`ifndef ACCEL_RD_DMA_DEFS_SVH
`define ACCEL_RD_DMA_DEFS_SVH

// Accelerators served by the DMA
`define ACCEL_COUNT 4

// One bank line and its byte count
`define DATA_WIDTH 32
`define KEEP_BYTES (`DATA_WIDTH / 8)

// Byte index inside a line
`define MASK_BITS ($clog2(`KEEP_BYTES))

// Byte address, line address and address inside one bank
`define ADDR_WIDTH 10
`define MEM_ADDR_WIDTH (`ADDR_WIDTH - `MASK_BITS)
`define BANK_ADDR_WIDTH (`MEM_ADDR_WIDTH - 1)

// Descriptor length in bytes and in whole lines
`define LEN_WIDTH 8
`define LINE_CNT_WIDTH (`LEN_WIDTH - `MASK_BITS)

`define DEST_WIDTH ($clog2(`ACCEL_COUNT))

// Lines buffered per accelerator
`define FIFO_LINES 2

`endif

//--- source/accel_rd_dma_pkg.sv
`default_nettype none

`include "accel_rd_dma_defs.svh"

package accel_rd_dma_pkg;

  // Accelerator id and one bit per accelerator
  typedef logic [`DEST_WIDTH-1:0]      accel_id_t;
  typedef logic [`ACCEL_COUNT-1:0]     accel_vec_t;

  // Byte address from the descriptor
  typedef logic [`ADDR_WIDTH-1:0]      byte_addr_t;

  // Line address, bit 0 picks the bank
  typedef logic [`MEM_ADDR_WIDTH-1:0]  line_addr_t;
  typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;

  typedef logic [`LEN_WIDTH-1:0]       byte_len_t;

  // Line payload and a byte index within it
  typedef logic [`DATA_WIDTH-1:0]      line_t;
  typedef logic [`MASK_BITS-1:0]       byte_ptr_t;

endpackage

`default_nettype wire

//--- source/dual_bank_ram.sv
`default_nettype none

`include "accel_rd_dma_defs.svh"

module dual_bank_ram (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               wr_en,
  input  wire accel_rd_dma_pkg::line_addr_t wr_addr,
  input  wire accel_rd_dma_pkg::line_t      wr_data,
  input  wire                               b1_rd_en,
  input  wire accel_rd_dma_pkg::bank_addr_t b1_rd_addr,
  output accel_rd_dma_pkg::line_t           b1_rd_data,
  input  wire                               b2_rd_en,
  input  wire accel_rd_dma_pkg::bank_addr_t b2_rd_addr,
  output accel_rd_dma_pkg::line_t           b2_rd_data
);
  import accel_rd_dma_pkg::*;

  localparam int BANK_LINES = 2 ** `BANK_ADDR_WIDTH;

  // Even lines live in bank 1, odd lines in bank 2
  line_t bank1 [BANK_LINES];
  line_t bank2 [BANK_LINES];

  bank_addr_t wr_word;

  assign wr_word = wr_addr[`MEM_ADDR_WIDTH-1:1];

  always_ff @(posedge clk) begin
    if (wr_en && !wr_addr[0])
      bank1[wr_word] <= wr_data;
    if (wr_en && wr_addr[0])
      bank2[wr_word] <= wr_data;
  end

  // Registered read, one cycle per bank
  always_ff @(posedge clk) begin
    if (rst) begin
      b1_rd_data <= '0;
      b2_rd_data <= '0;
    end else begin
      if (b1_rd_en)
        b1_rd_data <= bank1[b1_rd_addr];
      if (b2_rd_en)
        b2_rd_data <= bank2[b2_rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
  parameter int PORTS = 4,
  localparam int ENC_WIDTH = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire  [PORTS-1:0]     request,
  output logic [PORTS-1:0]     grant,
  output logic                 grant_valid,
  output logic [ENC_WIDTH-1:0] grant_encoded
);

  logic [ENC_WIDTH-1:0] last_grant;

  // Search starts one past the previous winner and wraps around
  always_comb begin : pick
    int idx;
    grant         = '0;
    grant_valid   = 1'b0;
    grant_encoded = '0;
    for (int k = 1; k <= PORTS; k++) begin
      idx = (int'(last_grant) + k) % PORTS;
      if (!grant_valid && request[idx]) begin
        grant_valid   = 1'b1;
        grant[idx]    = 1'b1;
        grant_encoded = ENC_WIDTH'(idx);
      end
    end
  end

  // Port 0 has first pick out of reset
  always_ff @(posedge clk) begin
    if (rst)
      last_grant <= ENC_WIDTH'(PORTS - 1);
    else if (grant_valid)
      last_grant <= grant_encoded;
  end

endmodule

`default_nettype wire

//--- source/simple_fifo.sv
`default_nettype none

module simple_fifo #(
  parameter int ADDR_WIDTH = 2,
  parameter int DATA_WIDTH = 8
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   clear,
  input  wire                   din_valid,
  input  wire  [DATA_WIDTH-1:0] din,
  output logic                  din_ready,
  output logic                  dout_valid,
  output logic [DATA_WIDTH-1:0] dout,
  input  wire                   dout_ready
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   count;
  logic                  push;
  logic                  pop;

  assign din_ready  = (count != DEPTH);
  assign dout_valid = (count != 0);
  assign dout       = mem[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  // Clear drops everything stored, including a write in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (ADDR_WIDTH+1)'(push) - (ADDR_WIDTH+1)'(pop);
    end
  end

endmodule

`default_nettype wire

//--- source/accel_rd_dma_sp.sv
`default_nettype none

`include "accel_rd_dma_defs.svh"

module accel_rd_dma_sp (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire accel_rd_dma_pkg::accel_id_t      desc_accel_id,
  input  wire accel_rd_dma_pkg::byte_addr_t     desc_addr,
  input  wire accel_rd_dma_pkg::byte_len_t      desc_len,
  input  wire                                   desc_valid,
  output accel_rd_dma_pkg::accel_vec_t          desc_error,
  input  wire accel_rd_dma_pkg::accel_vec_t     accel_stop,
  output accel_rd_dma_pkg::accel_vec_t          accel_busy,
  output accel_rd_dma_pkg::bank_addr_t          b1_rd_addr,
  output logic                                  b1_rd_en,
  input  wire accel_rd_dma_pkg::line_t          b1_rd_data,
  output accel_rd_dma_pkg::bank_addr_t          b2_rd_addr,
  output logic                                  b2_rd_en,
  input  wire accel_rd_dma_pkg::line_t          b2_rd_data,
  output wire [`ACCEL_COUNT*`DATA_WIDTH-1:0]    line_data,
  output wire [`ACCEL_COUNT*`MASK_BITS-1:0]     line_ptr,
  output wire accel_rd_dma_pkg::accel_vec_t     line_last,
  output wire accel_rd_dma_pkg::accel_vec_t     line_valid,
  input  wire accel_rd_dma_pkg::accel_vec_t     line_ready
);
  import accel_rd_dma_pkg::*;

  localparam int FIFO_WIDTH = 1 + `MASK_BITS + `DATA_WIDTH;

  accel_vec_t stop_r;

  // Parsed descriptor
  line_addr_t                 req_addr;
  byte_ptr_t                  req_offset;
  byte_ptr_t                  req_final_ptr;
  logic [`LINE_CNT_WIDTH-1:0] req_count;
  accel_id_t                  req_dest;
  accel_vec_t                 req_dest_1hot;
  logic                       req_v;
  logic                       req_last;
  byte_ptr_t                  remainder;

  assign remainder = desc_len[`MASK_BITS-1:0];
  assign req_last  = (req_count == 1);

  always_ff @(posedge clk) begin
    req_addr      <= desc_addr[`ADDR_WIDTH-1:`MASK_BITS];
    req_offset    <= desc_addr[`MASK_BITS-1:0];
    req_count     <= desc_len[`LEN_WIDTH-1:`MASK_BITS] + (remainder != 0);
    // Zero remainder wraps to the last byte of a full line
    req_final_ptr <= remainder - 1'b1;
    req_dest      <= desc_accel_id;
    req_dest_1hot <= accel_vec_t'(1) << desc_accel_id;
    req_v         <= desc_valid;
    if (rst)
      req_v <= 1'b0;
  end

  // Active entries, one per accelerator
  line_addr_t                 act_addr_mem   [`ACCEL_COUNT];
  logic [`LINE_CNT_WIDTH-1:0] act_count_mem  [`ACCEL_COUNT];
  byte_ptr_t                  act_final_mem  [`ACCEL_COUNT];
  byte_ptr_t                  act_offset_mem [`ACCEL_COUNT];
  accel_vec_t                 act_v;
  accel_vec_t                 act_v_next;

  accel_vec_t                 arb_request;
  accel_vec_t                 act_ack;
  accel_vec_t                 fifo_ready;
  accel_id_t                  act_enc;
  logic                       act_arb_v;

  line_addr_t                 act_addr;
  logic [`LINE_CNT_WIDTH-1:0] act_count;
  byte_ptr_t                  act_final_ptr;
  byte_ptr_t                  act_offset;
  logic                       act_last;

  assign act_addr      = act_addr_mem[act_enc];
  assign act_count     = act_count_mem[act_enc];
  assign act_final_ptr = act_final_mem[act_enc];
  assign act_offset    = act_offset_mem[act_enc];
  assign act_last      = (act_count == 1);

  // First line of a new descriptor goes out directly, the rest wait here
  always_ff @(posedge clk) begin
    if (req_v) begin
      act_addr_mem[req_dest]   <= req_addr + 1'b1;
      act_count_mem[req_dest]  <= req_count - 1'b1;
      act_final_mem[req_dest]  <= req_final_ptr;
      act_offset_mem[req_dest] <= req_offset;
    end else if (act_arb_v) begin
      act_addr_mem[act_enc]  <= act_addr + 1'b1;
      act_count_mem[act_enc] <= act_count - 1'b1;
    end
  end

  always_comb begin
    act_v_next = act_v;
    if (req_v)
      act_v_next[req_dest] = !req_last;
    else if (act_arb_v && act_last)
      act_v_next[act_enc] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst)
      act_v <= '0;
    else
      act_v <= act_v_next & ~stop_r;
  end

  // Arbitration only runs in cycles without a new descriptor
  assign arb_request = {`ACCEL_COUNT{!req_v}} & act_v & fifo_ready & ~stop_r;

  rr_arbiter #(
    .PORTS(`ACCEL_COUNT)
  ) act_arbiter (
    .clk          (clk),
    .rst          (rst),
    .request      (arb_request),
    .grant        (act_ack),
    .grant_valid  (act_arb_v),
    .grant_encoded(act_enc)
  );

  // Memory request stage
  line_addr_t sel_addr;
  line_addr_t sel_addr_n;
  logic       sel_last;

  assign sel_addr   = req_v ? req_addr : act_addr;
  assign sel_addr_n = sel_addr + 1'b1;
  assign sel_last   = req_v ? req_last : act_last;

  // Metadata that follows each read, index is cycles after the request
  accel_id_t  dest_pipe   [4];
  byte_ptr_t  ptr_pipe    [4];
  logic [3:0] last_pipe;
  logic [2:0] bank_pipe;
  byte_ptr_t  offset_pipe [3];
  logic [3:1] en_pipe;

  always_ff @(posedge clk) begin
    b1_rd_en <= act_arb_v || req_v;
    b2_rd_en <= act_arb_v || req_v;
    // An odd start line puts the second line in the next bank 1 word
    b1_rd_addr <= sel_addr[0] ? sel_addr_n[`MEM_ADDR_WIDTH-1:1] :
                                sel_addr[`MEM_ADDR_WIDTH-1:1];
    // Bank 2 word is the same for either parity
    b2_rd_addr <= sel_addr[`MEM_ADDR_WIDTH-1:1];

    dest_pipe[0]   <= req_v ? req_dest : act_enc;
    ptr_pipe[0]    <= !sel_last ? '1 : (req_v ? req_final_ptr : act_final_ptr);
    last_pipe[0]   <= sel_last;
    bank_pipe[0]   <= sel_addr[0];
    offset_pipe[0] <= req_v ? req_offset : act_offset;
    if (rst) begin
      b1_rd_en <= 1'b0;
      b2_rd_en <= 1'b0;
    end
  end

  line_t                      b1_data_rr;
  line_t                      b2_data_rr;
  line_t                      line_rrr;
  logic [2*`DATA_WIDTH-1:0]   line_pair;
  logic [2*`DATA_WIDTH-1:0]   line_shifted;

  // Lower address line sits in the low half before the offset shift
  assign line_pair    = bank_pipe[2] ? {b1_data_rr, b2_data_rr} :
                                       {b2_data_rr, b1_data_rr};
  assign line_shifted = line_pair >> {offset_pipe[2], 3'b000};

  always_ff @(posedge clk) begin
    for (int s = 1; s < 4; s++) begin
      dest_pipe[s] <= dest_pipe[s-1];
      ptr_pipe[s]  <= ptr_pipe[s-1];
    end
    for (int s = 1; s < 3; s++)
      offset_pipe[s] <= offset_pipe[s-1];
    last_pipe[3:1] <= last_pipe[2:0];
    bank_pipe[2:1] <= bank_pipe[1:0];

    b1_data_rr <= b1_rd_data;
    b2_data_rr <= b2_rd_data;
    line_rrr   <= line_shifted[`DATA_WIDTH-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst)
      en_pipe <= '0;
    else
      en_pipe <= {en_pipe[2:1], b1_rd_en};
  end

  // Stop stays set until the next descriptor for that accelerator
  always_ff @(posedge clk) begin
    if (rst) begin
      stop_r <= '0;
    end else begin
      stop_r <= stop_r | accel_stop;
      if (desc_valid)
        stop_r[desc_accel_id] <= 1'b0;
    end
  end

  accel_vec_t last_pop;

  assign last_pop = line_valid & line_last & line_ready;

  always_ff @(posedge clk) begin
    if (rst)
      accel_busy <= '0;
    else
      accel_busy <= (accel_busy | (req_v ? req_dest_1hot : '0)) & ~stop_r & ~last_pop;
  end

  always_ff @(posedge clk) begin
    if (rst)
      desc_error <= '0;
    else if (desc_valid && accel_busy[desc_accel_id])
      desc_error[desc_accel_id] <= 1'b1;
  end

  for (genvar i = 0; i < `ACCEL_COUNT; i++) begin : g_accel
    // Lines owed to this accelerator, in flight or buffered
    logic [$clog2(`FIFO_LINES):0] credit;
    logic                         issue;
    logic                         pop;

    assign issue = (req_v && req_dest_1hot[i]) || act_ack[i];
    assign pop   = line_valid[i] && line_ready[i];

    always_ff @(posedge clk) begin
      if (rst || stop_r[i])
        credit <= '0;
      else if (issue && !pop)
        credit <= credit + 1'b1;
      else if (pop && !issue)
        credit <= credit - 1'b1;
    end

    assign fifo_ready[i] = (credit < `FIFO_LINES);

    simple_fifo #(
      .ADDR_WIDTH($clog2(`FIFO_LINES)),
      .DATA_WIDTH(FIFO_WIDTH)
    ) accel_fifo (
      .clk       (clk),
      .rst       (rst),
      .clear     (stop_r[i]),
      .din_valid (en_pipe[3] && (dest_pipe[3] == i)),
      .din       ({last_pipe[3], ptr_pipe[3], line_rrr}),
      .din_ready (),
      .dout_valid(line_valid[i]),
      .dout      ({line_last[i], line_ptr[i*`MASK_BITS +: `MASK_BITS],
                   line_data[i*`DATA_WIDTH +: `DATA_WIDTH]}),
      .dout_ready(line_ready[i])
    );
  end

endmodule

`default_nettype wire

//--- source/accel_width_conv.sv
`default_nettype none

module accel_width_conv (
  input  wire                              clk,
  input  wire                              rst,
  input  wire accel_rd_dma_pkg::line_t     line_data,
  input  wire accel_rd_dma_pkg::byte_ptr_t line_ptr,
  input  wire                              line_last,
  input  wire                              line_valid,
  output logic                             line_ready,
  output logic [7:0]                       out_data,
  output logic                             out_last,
  output logic                             out_valid,
  input  wire                              out_ready
);
  import accel_rd_dma_pkg::*;

  byte_ptr_t rd_ptr;
  logic      advance;
  logic      last_byte;

  // Output register is free or being drained this cycle
  assign advance    = !out_valid || out_ready;
  assign last_byte  = (rd_ptr == line_ptr);
  assign line_ready = advance && last_byte;

  // A drop of line_valid without a handshake means a flush
  always_ff @(posedge clk) begin
    if (rst || !line_valid)
      rd_ptr <= '0;
    else if (advance)
      rd_ptr <= last_byte ? '0 : rd_ptr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= line_data[{rd_ptr, 3'b000} +: 8];
      out_last <= line_last && last_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else if (advance)
      out_valid <= line_valid;
  end

endmodule

`default_nettype wire

//--- source/accel_rd_top.sv
`default_nettype none

`include "accel_rd_dma_defs.svh"

module accel_rd_top (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               wr_en,
  input  wire accel_rd_dma_pkg::line_addr_t wr_addr,
  input  wire accel_rd_dma_pkg::line_t      wr_data,
  input  wire accel_rd_dma_pkg::accel_id_t  desc_accel_id,
  input  wire accel_rd_dma_pkg::byte_addr_t desc_addr,
  input  wire accel_rd_dma_pkg::byte_len_t  desc_len,
  input  wire                               desc_valid,
  output wire accel_rd_dma_pkg::accel_vec_t desc_error,
  input  wire accel_rd_dma_pkg::accel_vec_t accel_stop,
  output wire accel_rd_dma_pkg::accel_vec_t accel_busy,
  output wire [`ACCEL_COUNT*8-1:0]          out_data,
  output wire accel_rd_dma_pkg::accel_vec_t out_last,
  output wire accel_rd_dma_pkg::accel_vec_t out_valid,
  input  wire accel_rd_dma_pkg::accel_vec_t out_ready
);
  import accel_rd_dma_pkg::*;

  wire bank_addr_t                        b1_rd_addr;
  wire bank_addr_t                        b2_rd_addr;
  wire                                    b1_rd_en;
  wire                                    b2_rd_en;
  wire line_t                             b1_rd_data;
  wire line_t                             b2_rd_data;
  wire [`ACCEL_COUNT*`DATA_WIDTH-1:0]     line_data;
  wire [`ACCEL_COUNT*`MASK_BITS-1:0]      line_ptr;
  wire accel_vec_t                        line_last;
  wire accel_vec_t                        line_valid;
  wire accel_vec_t                        line_ready;

  dual_bank_ram ram_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .b1_rd_en  (b1_rd_en),
    .b1_rd_addr(b1_rd_addr),
    .b1_rd_data(b1_rd_data),
    .b2_rd_en  (b2_rd_en),
    .b2_rd_addr(b2_rd_addr),
    .b2_rd_data(b2_rd_data)
  );

  accel_rd_dma_sp dma_inst (
    .clk          (clk),
    .rst          (rst),
    .desc_accel_id(desc_accel_id),
    .desc_addr    (desc_addr),
    .desc_len     (desc_len),
    .desc_valid   (desc_valid),
    .desc_error   (desc_error),
    .accel_stop   (accel_stop),
    .accel_busy   (accel_busy),
    .b1_rd_addr   (b1_rd_addr),
    .b1_rd_en     (b1_rd_en),
    .b1_rd_data   (b1_rd_data),
    .b2_rd_addr   (b2_rd_addr),
    .b2_rd_en     (b2_rd_en),
    .b2_rd_data   (b2_rd_data),
    .line_data    (line_data),
    .line_ptr     (line_ptr),
    .line_last    (line_last),
    .line_valid   (line_valid),
    .line_ready   (line_ready)
  );

  // One byte-wide output stream per accelerator
  for (genvar i = 0; i < `ACCEL_COUNT; i++) begin : g_conv
    accel_width_conv conv_inst (
      .clk       (clk),
      .rst       (rst),
      .line_data (line_data[i*`DATA_WIDTH +: `DATA_WIDTH]),
      .line_ptr  (line_ptr[i*`MASK_BITS +: `MASK_BITS]),
      .line_last (line_last[i]),
      .line_valid(line_valid[i]),
      .line_ready(line_ready[i]),
      .out_data  (out_data[i*8 +: 8]),
      .out_last  (out_last[i]),
      .out_valid (out_valid[i]),
      .out_ready (out_ready[i])
    );
  end

endmodule

`default_nettype wire

//--- tb/accel_rd_tb.sv
`default_nettype none

`include "accel_rd_dma_defs.svh"

module accel_rd_tb;
  import accel_rd_dma_pkg::*;

  localparam int MEM_BYTES = 2 ** `ADDR_WIDTH;
  localparam int MEM_LINES = 2 ** `MEM_ADDR_WIDTH;

  typedef logic [7:0] byte_q_t [$];

  logic                      clk;
  logic                      rst;
  logic                      wr_en;
  line_addr_t                wr_addr;
  line_t                     wr_data;
  accel_id_t                 desc_accel_id;
  byte_addr_t                desc_addr;
  byte_len_t                 desc_len;
  logic                      desc_valid;
  accel_vec_t                desc_error;
  accel_vec_t                accel_stop;
  accel_vec_t                accel_busy;
  logic [`ACCEL_COUNT*8-1:0] out_data;
  accel_vec_t                out_last;
  accel_vec_t                out_valid;
  accel_vec_t                out_ready;

  // Byte image of the buffer as written through the write port
  logic [7:0] mem_model [MEM_BYTES];

  // Bytes still owed to each accelerator in arrival order
  logic [7:0] exp_q [`ACCEL_COUNT][$];
  accel_vec_t discard;
  int         dropped [`ACCEL_COUNT];

  // Random out_ready pattern replayed once per cycle
  accel_vec_t ready_force;
  accel_vec_t ready_random;
  accel_vec_t ready_pattern [1024];
  logic [9:0] ready_idx;

  int cycle_count;
  int total_bytes;
  int failures;

  accel_rd_top accel_rd_top_inst (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .desc_accel_id(desc_accel_id),
    .desc_addr    (desc_addr),
    .desc_len     (desc_len),
    .desc_valid   (desc_valid),
    .desc_error   (desc_error),
    .accel_stop   (accel_stop),
    .accel_busy   (accel_busy),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    failures++;
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at cycle %0d", cycle_count);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_vec(input string name, input accel_vec_t got, input accel_vec_t exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Model bytes from addr up to addr + len - 1
  function automatic byte_q_t expected_bytes(input byte_addr_t addr, input byte_len_t len);
    byte_q_t bytes;
    for (int k = 0; k < int'(len); k++)
      bytes.push_back(mem_model[(int'(addr) + k) % MEM_BYTES]);
    return bytes;
  endfunction

  task automatic send_desc(input accel_id_t id, input byte_addr_t addr, input byte_len_t len,
                           input logic expect_data);
    byte_q_t bytes;
    bytes = expected_bytes(addr, len);
    if (expect_data) begin
      foreach (bytes[k])
        exp_q[id].push_back(bytes[k]);
    end
    total_bytes += int'(len);
    @(posedge clk);
    desc_valid    <= 1'b1;
    desc_accel_id <= id;
    desc_addr     <= addr;
    desc_len      <= len;
    @(posedge clk);
    desc_valid    <= 1'b0;
  endtask

  task automatic pulse_stop(input accel_id_t id);
    @(posedge clk);
    accel_stop <= accel_vec_t'(1) << id;
    @(posedge clk);
    accel_stop <= '0;
  endtask

  task automatic reset_dut();
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
  endtask

  // Returns once every queue is drained and no accelerator is busy
  task automatic wait_all_idle();
    logic pending;
    pending = 1'b1;
    while (pending) begin
      @(posedge clk);
      pending = (accel_busy != '0);
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        if (exp_q[i].size() != 0)
          pending = 1'b1;
      end
    end
  endtask

  initial begin : ready_driver
    out_ready <= '0;
    ready_idx = '0;
    forever begin
      @(posedge clk);
      out_ready <= (ready_force & ~ready_random) | (ready_random & ready_pattern[ready_idx]);
      ready_idx = ready_idx + 1'b1;
    end
  end

  always @(posedge clk) begin : compare
    logic [7:0] exp_byte;
    if (!rst) begin
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        if (out_valid[i] && out_ready[i]) begin
          if (discard[i]) begin
            dropped[i]++;
          end else if (exp_q[i].size() == 0) begin
            $display("Accelerator %0d sent a byte that no descriptor asked for", i);
            abort_run();
          end else begin
            exp_byte = exp_q[i].pop_front();
            check_byte($sformatf("out_data[%0d]", i), out_data[i*8 +: 8], exp_byte);
            check_last($sformatf("out_last[%0d]", i), out_last[i], exp_q[i].size() == 0);
          end
        end
      end
    end
  end

  // Limit grows with every byte that a descriptor asks for
  always @(posedge clk) begin : watchdog
    cycle_count = cycle_count + 1;
    if (cycle_count > 20 * total_bytes + 2000) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_count - 1);
      abort_run();
    end
  end

  initial begin : main
    byte_addr_t addr;
    byte_len_t  len;
    line_t      word;

    void'($urandom(32'h9620));
    cycle_count = 0;
    total_bytes = 0;
    failures    = 0;
    discard     = '0;
    foreach (dropped[i])
      dropped[i] = 0;
    for (int k = 0; k < 1024; k++)
      ready_pattern[k] = accel_vec_t'($urandom);

    rst           <= 1'b1;
    wr_en         <= 1'b0;
    wr_addr       <= '0;
    wr_data       <= '0;
    desc_accel_id <= '0;
    desc_addr     <= '0;
    desc_len      <= '0;
    desc_valid    <= 1'b0;
    accel_stop    <= '0;
    ready_force   <= '1;
    ready_random  <= '0;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_vec("accel_busy", accel_busy, '0);
    check_vec("desc_error", desc_error, '0);
    check_vec("out_valid", out_valid, '0);

    // Fill the buffer and the byte model line by line
    for (int a = 0; a < MEM_LINES; a++) begin
      word = line_t'($urandom);
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= line_addr_t'(a);
      wr_data <= word;
      for (int k = 0; k < `KEEP_BYTES; k++)
        mem_model[a*`KEEP_BYTES + k] = word[8*k +: 8];
    end
    @(posedge clk);
    wr_en <= 1'b0;

    // Aligned transfer of whole lines
    send_desc(0, 128, 32, 1'b1);
    wait_all_idle();

    // Every start offset with short tails and reads across both banks
    for (int off = 0; off < 4; off++) begin
      for (int n = 0; n < `ACCEL_COUNT; n++) begin
        addr = byte_addr_t'(4 * (5 + 9 * (4 * off + n)) + off);
        len  = byte_len_t'(1 + 5 * n + off);
        send_desc(accel_id_t'(n), addr, len, 1'b1);
      end
      wait_all_idle();
    end

    // All accelerators at once with random back-pressure
    ready_random <= '1;
    for (int r = 0; r < 3; r++) begin
      for (int n = 0; n < `ACCEL_COUNT; n++) begin
        addr = byte_addr_t'($urandom % 640);
        len  = byte_len_t'($urandom % 255 + 1);
        send_desc(accel_id_t'(n), addr, len, 1'b1);
      end
      wait_all_idle();
    end
    ready_random <= '0;
    check_vec("desc_error", desc_error, '0);

    // Busy follows a single transfer on accelerator 2
    send_desc(2, 40, 40, 1'b1);
    repeat (2) @(posedge clk);
    check_vec("accel_busy", accel_busy, accel_vec_t'(1) << 2);
    while (exp_q[2].size() > 4) begin
      @(posedge clk);
      check_last("accel_busy[2]", accel_busy[2], 1'b1);
    end
    while (exp_q[2].size() != 0)
      @(posedge clk);
    @(posedge clk);
    check_vec("accel_busy", accel_busy, '0);

    // Second descriptor to a busy accelerator with its data ignored
    discard[1] = 1'b1;
    send_desc(1, 200, 60, 1'b0);
    repeat (2) @(posedge clk);
    check_vec("accel_busy", accel_busy, accel_vec_t'(1) << 1);
    send_desc(1, 300, 20, 1'b0);
    @(posedge clk);
    check_vec("desc_error", desc_error, accel_vec_t'(1) << 1);
    pulse_stop(1);
    repeat (3) @(posedge clk);
    check_vec("accel_busy", accel_busy, '0);
    repeat (30) @(posedge clk);
    check_vec("desc_error", desc_error, accel_vec_t'(1) << 1);
    reset_dut();
    check_vec("desc_error", desc_error, '0);
    check_vec("accel_busy", accel_busy, '0);
    check_vec("out_valid", out_valid, '0);
    discard[1] = 1'b0;

    // Stop accelerator 3 while its output is stalled
    ready_force <= ~(accel_vec_t'(1) << 3);
    send_desc(3, 400, 100, 1'b1);
    repeat (30) @(posedge clk);
    check_vec("accel_busy", accel_busy, accel_vec_t'(1) << 3);
    discard[3] = 1'b1;
    exp_q[3].delete();
    dropped[3] = 0;
    pulse_stop(3);
    repeat (3) @(posedge clk);
    check_vec("accel_busy", accel_busy, '0);
    ready_force <= '1;
    repeat (20) @(posedge clk);
    if (dropped[3] > 1) begin
      $display("Accelerator 3 sent %0d bytes after its stop, at most one was allowed",
               dropped[3]);
      abort_run();
    end
    check_vec("out_valid", out_valid, '0);
    discard[3] = 1'b0;
    send_desc(3, 500, 37, 1'b1);
    wait_all_idle();
    check_vec("desc_error", desc_error, '0);

    repeat (5) @(posedge clk);
    if (failures == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- accel_rd_dma.f
+incdir+include
source/accel_rd_dma_pkg.sv
source/dual_bank_ram.sv
source/rr_arbiter.sv
source/simple_fifo.sv
source/accel_rd_dma_sp.sv
source/accel_width_conv.sv
source/accel_rd_top.sv
tb/accel_rd_tb.sv
